/* source/sccb_tx_pkg.sv */
package sccb_tx_pkg;

	////////////////////////////////////////////////////////////
	// Word geometry

	// Four 8b10b symbols per SERDES word
	localparam int unsigned SYMBOL_COUNT = 4;
	localparam int unsigned LANE_BITS = 8;
	localparam int unsigned WORD_BITS = SYMBOL_COUNT * LANE_BITS;

	// One symbol, CRC value or sequence number
	typedef logic [LANE_BITS-1:0] byte_t;

	// Lane n at bits 8n+7 down to 8n
	typedef logic [WORD_BITS-1:0] word_t;

	// One K flag per lane
	typedef logic [SYMBOL_COUNT-1:0] kmask_t;

	// Valid byte count, 0 to 4
	typedef logic [2:0] nbytes_t;

	// Lane index of the CRC byte
	typedef logic [1:0] crc_pos_t;

	////////////////////////////////////////////////////////////
	// Control codes

	// K28.5
	localparam byte_t IDLE_CODE = 8'hBC;
	// Data byte that follows K28.5 in an idle word
	localparam byte_t IDLE_FILL = 8'hB5;
	// K28.6, end of frame
	localparam byte_t STOP_CODE = 8'hDC;

	// CRC-8-ATM, x^8+x^2+x+1
	localparam byte_t CRC_POLY = 8'h07;

	////////////////////////////////////////////////////////////
	// Word types

	// Word from the transaction layer
	typedef struct packed {
		logic start;
		nbytes_t valid;
		word_t data;
	} ll_word_t;

	// Word toward the SERDES
	typedef struct packed {
		kmask_t kchar;
		word_t data;
	} serdes_word_t;

	// Where the CRC byte goes in the word of the same stage
	typedef struct packed {
		logic last;
		crc_pos_t pos;
	} crc_slot_t;

	// Transmit framing states
	typedef enum logic [1:0] {
		IDLE,
		BODY,
		CRC_SLOT
	} frame_state_t;

	// One byte into the CRC, MSB first, no reflection
	function automatic byte_t crc8_atm_byte(byte_t crc_in, byte_t din);
		byte_t c;
		c = crc_in ^ din;
		for (int b = 0; b < LANE_BITS; b++) begin
			c = c[7] ? ({c[6:0], 1'b0} ^ CRC_POLY) : {c[6:0], 1'b0};
		end
		return c;
	endfunction

endpackage

/* source/crc8_atm_engine.sv */
module crc8_atm_engine (
	input logic tx_clk,
	input logic arst_n,
	// Start a new frame from zero
	input logic restart,
	input sccb_tx_pkg::word_t din,
	// Lane bound, lanes below this carry bytes
	input sccb_tx_pkg::nbytes_t din_len,
	// Lowest lane that takes part
	input sccb_tx_pkg::crc_pos_t first_lane,
	output sccb_tx_pkg::byte_t crc
);

	import sccb_tx_pkg::*;

	////////////////////////////////////////////////////////////
	// Combinational fold

	byte_t crc_seed;
	byte_t crc_next;

	// A new frame starts from zero, otherwise keep accumulating
	always_comb begin
		crc_seed = restart ? '0 : crc;
	end

	// Lanes first_lane up to din_len-1, lane 0 side first
	// din_len of 0 leaves the value alone
	always_comb begin
		crc_next = crc_seed;
		for (int i = 0; i < SYMBOL_COUNT; i++) begin
			if ((crc_pos_t'(i) >= first_lane) && (nbytes_t'(i) < din_len)) begin
				crc_next = crc8_atm_byte(crc_next, din[i*LANE_BITS +: LANE_BITS]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Result register

	// Visible one edge after the bytes arrive
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc <= '0;
		end else begin
			crc <= crc_next;
		end
	end

endmodule

/* source/tx_frame_fsm.sv */
module tx_frame_fsm (
	input logic tx_clk,
	input logic arst_n,
	// Word from the transaction layer
	input sccb_tx_pkg::ll_word_t ll,
	// Framed word, one stage ahead of the output
	output sccb_tx_pkg::serdes_word_t adv,
	// CRC position for the word in adv
	output sccb_tx_pkg::crc_slot_t slot
);

	import sccb_tx_pkg::*;

	////////////////////////////////////////////////////////////
	// State

	frame_state_t state;
	frame_state_t state_next;

	// Sequence number of the next frame, wraps at 255
	byte_t seq;
	byte_t seq_next;

	serdes_word_t adv_next;
	crc_slot_t slot_next;

	////////////////////////////////////////////////////////////
	// Next word and state

	always_comb begin
		state_next = state;
		seq_next = seq;

		// Idle word unless something else applies
		// K28.5 in lane 0, fill byte in lane 1, zero padding
		adv_next.kchar = 4'b0001;
		adv_next.data = {16'h0000, IDLE_FILL, IDLE_CODE};

		// No CRC in this word by default
		slot_next.last = 1'b0;
		slot_next.pos = 2'd0;

		case (state)
			IDLE: begin
				if (ll.start) begin
					// Start code in lane 0 passes through as a K character
					adv_next.data = ll.data;
					// Lane 1 is ours
					adv_next.data[15:8] = seq;
					seq_next = seq + 1'b1;

					if (ll.valid == 3'd3) begin
						// Frame ends in the start word itself
						// Stop in lane 3, CRC follows in a word of its own
						adv_next.kchar = 4'b1001;
						adv_next.data[31:24] = STOP_CODE;
						state_next = CRC_SLOT;
					end else begin
						state_next = BODY;
					end
				end
			end

			BODY: begin
				case (ll.valid)
					// Full payload word
					3'd4: begin
						adv_next.kchar = 4'b0000;
						adv_next.data = ll.data;
					end

					// Three bytes, stop in lane 3
					// No room for the CRC here
					3'd3: begin
						adv_next.kchar = 4'b1000;
						adv_next.data = {STOP_CODE, ll.data[23:0]};
						state_next = CRC_SLOT;
					end

					// Two bytes, stop, CRC in lane 3
					3'd2: begin
						adv_next.kchar = 4'b0100;
						adv_next.data = {8'h00, STOP_CODE, ll.data[15:0]};
						slot_next.last = 1'b1;
						slot_next.pos = 2'd3;
						state_next = IDLE;
					end

					// One byte, stop, CRC in lane 2, padding
					3'd1: begin
						adv_next.kchar = 4'b0010;
						adv_next.data = {16'h0000, STOP_CODE, ll.data[7:0]};
						slot_next.last = 1'b1;
						slot_next.pos = 2'd2;
						state_next = IDLE;
					end

					// Previous word was the last full one
					// Stop in lane 0, CRC in lane 1, padding
					default: begin
						adv_next.kchar = 4'b0001;
						adv_next.data = {24'h000000, STOP_CODE};
						slot_next.last = 1'b1;
						slot_next.pos = 2'd1;
						state_next = IDLE;
					end
				endcase
			end

			CRC_SLOT: begin
				// Carrier word for the CRC of a lane 3 stop
				// A start here is dropped
				adv_next.kchar = 4'b0000;
				adv_next.data = '0;
				slot_next.last = 1'b1;
				slot_next.pos = 2'd0;
				state_next = IDLE;
			end

			default: begin
				state_next = IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Registers

	// adv reset to zero so the output stays zero until the first idle
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			seq <= '0;
			adv <= '0;
			slot <= '0;
		end else begin
			state <= state_next;
			seq <= seq_next;
			adv <= adv_next;
			slot <= slot_next;
		end
	end

endmodule

/* source/tx_crc_inserter.sv */
module tx_crc_inserter (
	input logic tx_clk,
	input logic arst_n,
	// Framed word from the FSM
	input sccb_tx_pkg::serdes_word_t adv,
	// Where the CRC goes, if anywhere
	input sccb_tx_pkg::crc_slot_t slot,
	// Settled CRC of the frame
	input sccb_tx_pkg::byte_t crc,
	// Word to the SERDES
	output sccb_tx_pkg::serdes_word_t out
);

	import sccb_tx_pkg::*;

	////////////////////////////////////////////////////////////
	// CRC merge

	serdes_word_t merged;

	// Lane slot.pos is padding in adv, so just overwrite it
	always_comb begin
		merged = adv;
		if (slot.last) begin
			merged.data[slot.pos*LANE_BITS +: LANE_BITS] = crc;
			// CRC is a data symbol
			merged.kchar[slot.pos] = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register

	// Zero after reset, idles show up two edges later
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			out <= '0;
		end else begin
			out <= merged;
		end
	end

endmodule

/* source/sccb_tx_link.sv */
module sccb_tx_link (
	input logic tx_clk,
	input logic arst_n,
	// Transaction layer side
	input logic tx_ll_start,
	input sccb_tx_pkg::nbytes_t tx_ll_valid,
	input sccb_tx_pkg::word_t tx_ll_data,
	// SERDES side
	output sccb_tx_pkg::kmask_t tx_kchar,
	output sccb_tx_pkg::word_t tx_data
);

	import sccb_tx_pkg::*;

	ll_word_t ll;
	serdes_word_t adv;
	crc_slot_t slot;
	serdes_word_t out;
	byte_t crc;

	// Inputs as one word
	assign ll.start = tx_ll_start;
	assign ll.valid = tx_ll_valid;
	assign ll.data = tx_ll_data;

	////////////////////////////////////////////////////////////
	// CRC feed

	// Only a lane 3 stop sets kchar[3] in adv
	// so the FSM is in CRC_SLOT and drops this input word
	logic crc_hold;
	assign crc_hold = adv.kchar[3];

	logic crc_restart;
	nbytes_t crc_len;
	crc_pos_t crc_first;

	assign crc_restart = tx_ll_start && !crc_hold;
	assign crc_len = crc_hold ? 3'd0 : tx_ll_valid;
	// Start word carries payload from lane 2 up
	assign crc_first = tx_ll_start ? 2'd2 : 2'd0;

	crc8_atm_engine crc8_atm_engine_inst (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.restart(crc_restart),
		.din(tx_ll_data),
		.din_len(crc_len),
		.first_lane(crc_first),
		.crc(crc)
	);

	////////////////////////////////////////////////////////////
	// Framing and output

	tx_frame_fsm tx_frame_fsm_inst (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.ll(ll),
		.adv(adv),
		.slot(slot)
	);

	tx_crc_inserter tx_crc_inserter_inst (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.adv(adv),
		.slot(slot),
		.crc(crc),
		.out(out)
	);

	assign tx_kchar = out.kchar;
	assign tx_data = out.data;

endmodule

/* bench/tx_link_model.svh */
`ifndef TX_LINK_MODEL_SVH
`define TX_LINK_MODEL_SVH

////////////////////////////////////////////////////////////
// Link control symbols

// K28.5 idle symbol and the data byte after it
localparam logic [7:0] K28_5_CODE = 8'hBC;
localparam logic [7:0] IDLE_FILL_BYTE = 8'hB5;
// K28.6 end of frame
localparam logic [7:0] K28_6_CODE = 8'hDC;

// Expected words are {kchar[3:0], data[31:0]}

////////////////////////////////////////////////////////////
// CRC-8-ATM reference

// Serial LFSR form, one message bit per step, MSB first
function automatic logic [7:0] crc8_serial_update(input logic [7:0] crc, input logic [7:0] b);
	logic [7:0] c;
	logic fb;
	c = crc;
	for (int i = 7; i >= 0; i--) begin
		fb = c[7] ^ b[i];
		c = {c[6:0], 1'b0};
		// x^2 + x + 1 taps
		if (fb) begin
			c = c ^ 8'h07;
		end
	end
	return c;
endfunction

////////////////////////////////////////////////////////////
// Expected output words

// K28.5, fill byte, zero padding
function automatic logic [35:0] idle_word();
	return {4'b0001, 16'h0000, IDLE_FILL_BYTE, K28_5_CODE};
endfunction

// Start code passes, lane 1 becomes the sequence number
function automatic logic [35:0] start_word(input logic [7:0] code, input logic [7:0] seq,
		input logic [7:0] l2, input logic [7:0] l3);
	return {4'b0001, l3, l2, seq, code};
endfunction

// Start word that ends the frame, stop in lane 3
function automatic logic [35:0] start_end_word(input logic [7:0] code,
		input logic [7:0] seq, input logic [7:0] l2);
	return {4'b1001, K28_6_CODE, l2, seq, code};
endfunction

function automatic logic [35:0] body_word(input logic [31:0] data);
	return {4'b0000, data};
endfunction

// Placement table for the last word of a frame
// rem is the number of final payload bytes
function automatic logic [35:0] end_word(input int rem, input logic [31:0] data,
		input logic [7:0] crc);
	case (rem)
		0: return {4'b0001, 16'h0000, crc, K28_6_CODE};
		1: return {4'b0010, 8'h00, crc, K28_6_CODE, data[7:0]};
		2: return {4'b0100, crc, K28_6_CODE, data[15:0]};
		default: return {4'b1000, K28_6_CODE, data[23:0]};
	endcase
endfunction

// Extra word after a lane 3 stop
function automatic logic [35:0] crc_word(input logic [7:0] crc);
	return {4'b0000, 24'h000000, crc};
endfunction

`endif

/* bench/tx_link_tb.sv */
module tx_link_tb;

	timeunit 1ns;
	timeprecision 1ps;

	`include "tx_link_model.svh"

	// K27.7 as the frame start code
	localparam logic [7:0] START_CODE = 8'hFB;

	////////////////////////////////////////////////////////////
	// Run length budget

	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 8;
	// Up to 7 bytes, worst case three words plus CRC slot or gap
	localparam int SMALL_FRAME_CYCLES = 4;
	// Up to 17 bytes, five words, CRC slot and gap
	localparam int LARGE_FRAME_CYCLES = 7;
	localparam int TEST_CYCLES = RESET_CYCLES + IDLE_CYCLES + 7 * SMALL_FRAME_CYCLES
		+ 20 * LARGE_FRAME_CYCLES + 260 * 2 + (4 * SMALL_FRAME_CYCLES + 5) + 3;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 50;

	logic tx_clk;
	logic arst_n;
	logic tx_ll_start;
	logic [2:0] tx_ll_valid;
	logic [31:0] tx_ll_data;
	logic [3:0] tx_kchar;
	logic [31:0] tx_data;

	// Expected words and the negedge at which each is due
	logic [35:0] exp_q[$];
	int due_q[$];
	int neg_count = 0;

	logic [31:0] lcg_state = 32'd27215;
	// Sequence number the next accepted frame must carry
	logic [7:0] exp_seq = 8'h00;

	sccb_tx_link sccb_tx_link_inst (
		.tx_clk(tx_clk),
		.arst_n(arst_n),
		.tx_ll_start(tx_ll_start),
		.tx_ll_valid(tx_ll_valid),
		.tx_ll_data(tx_ll_data),
		.tx_kchar(tx_kchar),
		.tx_data(tx_data)
	);

	initial begin
		tx_clk = 1'b0;
		forever #10 tx_clk = ~tx_clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// One input word, its output is due three negedges on
	task automatic drive_cycle(input bit start, input logic [2:0] valid, input logic [31:0] data,
			input logic [35:0] exp_word);
		@(posedge tx_clk);
		tx_ll_start <= start;
		tx_ll_valid <= valid;
		tx_ll_data <= data;
		exp_q.push_back(exp_word);
		due_q.push_back(neg_count + 3);
	endtask

	task automatic drive_idle(input int n);
		repeat (n) drive_cycle(1'b0, 3'd0, 32'd0, idle_word());
	endtask

	task automatic apply_reset();
		repeat (RESET_CYCLES) @(posedge tx_clk);
		// Output is zero, not idle, while reset is held
		check_value("tx_kchar", {28'd0, tx_kchar}, 32'd0);
		check_value("tx_data", tx_data, 32'd0);
		arst_n <= 1'b1;
	endtask

	// Random payload of len bytes, len 1 ends in the start word
	// slot_start drives a start that must be dropped in the CRC slot
	task automatic send_frame(input int len, input bit slot_start);
		logic [7:0] pay[$];
		logic [7:0] crc;
		logic [31:0] word;
		int idx;
		int rem;
		crc = 8'h00;
		for (int i = 0; i < len; i++) begin
			pay.push_back(rand_byte());
			crc = crc8_serial_update(crc, pay[i]);
		end
		if (len == 1) begin
			// Lane 3 junk is replaced by the stop symbol
			word = {rand_byte(), pay[0], rand_byte(), START_CODE};
			drive_cycle(1'b1, 3'd3, word, start_end_word(START_CODE, exp_seq, pay[0]));
			exp_seq = exp_seq + 8'd1;
			rem = 3;
		end else begin
			// Lane 1 junk is replaced by the sequence number
			word = {pay[1], pay[0], rand_byte(), START_CODE};
			drive_cycle(1'b1, 3'd4, word, start_word(START_CODE, exp_seq, pay[0], pay[1]));
			exp_seq = exp_seq + 8'd1;
			idx = 2;
			while (len - idx >= 4) begin
				word = {pay[idx + 3], pay[idx + 2], pay[idx + 1], pay[idx]};
				drive_cycle(1'b0, 3'd4, word, body_word(word));
				idx = idx + 4;
			end
			rem = len - idx;
			// Lanes above the final bytes carry junk
			word = lcg_next();
			for (int i = 0; i < rem; i++) begin
				word[8 * i +: 8] = pay[idx + i];
			end
			drive_cycle(1'b0, 3'(rem), word, end_word(rem, word, crc));
		end
		if (rem == 3) begin
			if (slot_start) begin
				drive_cycle(1'b1, 3'd4, lcg_next(), crc_word(crc));
			end else begin
				drive_cycle(1'b0, 3'd0, 32'd0, crc_word(crc));
			end
		end
	endtask

	task automatic wait_for_drain();
		while (exp_q.size() != 0) begin
			@(posedge tx_clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic idle_after_reset();
		drive_idle(IDLE_CYCLES);
	endtask

	// Start-only end, valid 0 to 3, then valid 0 and 1 behind a body word
	task automatic frame_end_cases();
		for (int len = 1; len <= 7; len++) begin
			send_frame(len, 1'b0);
			drive_idle(1);
		end
	endtask

	task automatic random_frame_crc();
		int len;
		logic [31:0] r;
		repeat (20) begin
			r = lcg_next();
			len = 2 + int'(r % 32'd16);
			send_frame(len, 1'b0);
			// Back to back or one idle between frames
			drive_idle(int'(r[8]));
		end
	endtask

	// Shortest frames back to back so the counter wraps
	task automatic sequence_wrap();
		repeat (260) send_frame(2, 1'b0);
		drive_idle(1);
	endtask

	task automatic start_in_crc_slot();
		send_frame(5, 1'b1);
		drive_idle(2);
		send_frame(2, 1'b0);
		drive_idle(1);
		send_frame(1, 1'b1);
		drive_idle(1);
		send_frame(3, 1'b0);
		drive_idle(1);
	endtask

	////////////////////////////////////////////////////////////
	// Output compare and timeout

	always @(negedge tx_clk) begin : output_monitor
		logic [35:0] exp_word;
		neg_count = neg_count + 1;
		if (neg_count > TIMEOUT_CYCLES) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end else if (due_q.size() != 0 && due_q[0] == neg_count) begin
			exp_word = exp_q.pop_front();
			void'(due_q.pop_front());
			check_value("tx_kchar", {28'd0, tx_kchar}, {28'd0, exp_word[35:32]});
			check_value("tx_data", tx_data, exp_word[31:0]);
		end
	end

	initial begin
		arst_n = 1'b0;
		tx_ll_start = 1'b0;
		tx_ll_valid = 3'd0;
		tx_ll_data = 32'd0;
		apply_reset();
		idle_after_reset();
		frame_end_cases();
		random_frame_crc();
		sequence_wrap();
		start_in_crc_slot();
		wait_for_drain();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* all.f */
+incdir+bench
source/sccb_tx_pkg.sv
source/crc8_atm_engine.sv
source/tx_frame_fsm.sv
source/tx_crc_inserter.sv
source/sccb_tx_link.sv
bench/tx_link_tb.sv

/* Makefile */
# Verilator flow for the transmit link

TB_TOP  = tx_link_tb
RTL_TOP = sccb_tx_link

.PHONY: all lint sim clean

all: sim

# RTL top level only
lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f all.f --top-module $(RTL_TOP)

# Build and run, a $fatal gives a failing exit status
sim:
	verilator --binary --timing --timescale 1ns/1ps -f all.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir
